/* hw/ieu_pkg.sv */
//////////////////////////////////////////////////
// Integer execution unit shared definitions
// Widths, opcode and ALU function enums, bus structs
//////////////////////////////////////////////////

package ieu_pkg;

    localparam int DATA_WIDTH    = 32;     // Operand and result width
    localparam int ADDR_WIDTH    = 32;     // Instruction address width
    localparam int ROB_IDX_WIDTH = 5;      // Reorder buffer tag width
    localparam int SHAMT_WIDTH   = 5;

    // Operation class as already sorted by the reservation station
    typedef enum logic [2:0] {
        OPC_LUI    = 3'd0,
        OPC_AUIPC  = 3'd1,
        OPC_JAL    = 3'd2,
        OPC_JALR   = 3'd3,
        OPC_BRANCH = 3'd4,
        OPC_OPIMM  = 3'd5,
        OPC_OP     = 3'd6
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_EQ   = 4'd10,  // Branch comparisons from here on
        ALU_NE   = 4'd11,
        ALU_LT   = 4'd12,
        ALU_GE   = 4'd13,
        ALU_LTU  = 4'd14,
        ALU_GEU  = 4'd15
    } alu_func_e;

    typedef struct packed {
        logic                     valid;
        opcode_e                  opcode;
        logic [ADDR_WIDTH-1:0]    iaddr;
        logic [DATA_WIDTH-1:0]    insn;
        logic [DATA_WIDTH-1:0]    src_a;
        logic [DATA_WIDTH-1:0]    src_b;
        logic [ROB_IDX_WIDTH-1:0] tag;
    } fu_req_t;

    // Decoded operation handed from ID to EX
    typedef struct packed {
        logic                     valid;
        alu_func_e                alu_func;
        logic [DATA_WIDTH-1:0]    src_a;
        logic [DATA_WIDTH-1:0]    src_b;
        logic [ADDR_WIDTH-1:0]    iaddr;
        logic [DATA_WIDTH-1:0]    imm_b;     // Offset for the target adder
        logic [SHAMT_WIDTH-1:0]   shamt;
        logic [ROB_IDX_WIDTH-1:0] tag;
        logic                     jmp;
        logic                     br;
    } ex_op_t;

    typedef struct packed {
        logic                     en;
        logic                     redirect;
        logic [DATA_WIDTH-1:0]    data;
        logic [ADDR_WIDTH-1:0]    addr;
        logic [ROB_IDX_WIDTH-1:0] tag;
    } cdb_t;

endpackage

/* hw/ieu_id.sv */
//////////////////////////////////////////////////
// Decode stage of the integer execution unit
//////////////////////////////////////////////////

`timescale 1ns/1ns

module ieu_id (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_flush,
    input  ieu_pkg::fu_req_t i_fu_req,
    output ieu_pkg::ex_op_t  o_ex_op
);

    import ieu_pkg::*;

    logic [DATA_WIDTH-1:0] insn;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [DATA_WIDTH-1:0] imm_i;
    logic [DATA_WIDTH-1:0] imm_u;
    logic [DATA_WIDTH-1:0] imm_j;
    logic [DATA_WIDTH-1:0] imm_br;
    logic                  is_op;
    alu_func_e             arith_func;
    alu_func_e             br_func;
    ex_op_t                ex_op_d;

    //////////////////////////////////////////////////
    // Instruction fields

    assign insn   = i_fu_req.insn;
    assign funct3 = insn[14:12];
    assign funct7 = insn[31:25];
    assign is_op  = (i_fu_req.opcode == OPC_OP);

    assign imm_i  = {{(DATA_WIDTH-12){insn[31]}}, insn[31:20]};
    assign imm_u  = {insn[31:12], 12'b0};
    assign imm_j  = {{(DATA_WIDTH-20){insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    assign imm_br = {{(DATA_WIDTH-12){insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};

    // Register and immediate forms share one funct3 map, only OP can subtract
    always_comb begin
        case (funct3)
            3'b000:  arith_func = (is_op && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_func = ALU_SLL;
            3'b010:  arith_func = ALU_SLT;
            3'b011:  arith_func = ALU_SLTU;
            3'b100:  arith_func = ALU_XOR;
            3'b101:  arith_func = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_func = ALU_OR;
            default: arith_func = ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b001:  br_func = ALU_NE;
            3'b100:  br_func = ALU_LT;
            3'b101:  br_func = ALU_GE;
            3'b110:  br_func = ALU_LTU;
            3'b111:  br_func = ALU_GEU;
            default: br_func = ALU_EQ;  // Reserved encodings fall back to BEQ
        endcase
    end

    //////////////////////////////////////////////////
    // Operand selection

    always_comb begin
        ex_op_d.valid    = i_fu_req.valid;
        ex_op_d.alu_func = ALU_ADD;
        ex_op_d.src_a    = i_fu_req.src_a;
        ex_op_d.src_b    = i_fu_req.src_b;
        ex_op_d.iaddr    = i_fu_req.iaddr;
        ex_op_d.imm_b    = imm_i;                          // JALR offset
        ex_op_d.shamt    = i_fu_req.src_b[SHAMT_WIDTH-1:0];
        ex_op_d.tag      = i_fu_req.tag;
        ex_op_d.jmp      = 1'b0;
        ex_op_d.br       = 1'b0;

        case (i_fu_req.opcode)
            OPC_LUI: begin
                ex_op_d.src_a = '0;
                ex_op_d.src_b = imm_u;
            end
            OPC_AUIPC: begin
                ex_op_d.src_a = i_fu_req.iaddr;
                ex_op_d.src_b = imm_u;
            end
            OPC_JAL: begin
                ex_op_d.src_a = i_fu_req.iaddr;              // Target base is the PC
                ex_op_d.imm_b = imm_j;
                ex_op_d.jmp   = 1'b1;
            end
            OPC_JALR: ex_op_d.jmp = 1'b1;
            OPC_BRANCH: begin
                ex_op_d.alu_func = br_func;
                ex_op_d.imm_b    = imm_br;
                ex_op_d.br       = 1'b1;
            end
            OPC_OPIMM: begin
                ex_op_d.alu_func = arith_func;
                ex_op_d.src_b    = imm_i;
                ex_op_d.shamt    = insn[20 +: SHAMT_WIDTH];
            end
            OPC_OP: ex_op_d.alu_func = arith_func;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        o_ex_op <= ex_op_d;
        if (!i_rst_n || i_flush) begin
            o_ex_op.valid <= 1'b0;
        end
    end

endmodule

/* hw/ieu_ex.sv */
//////////////////////////////////////////////////
// Execute stage of the integer execution unit
// ALU, target adder and CDB output register
//////////////////////////////////////////////////

`timescale 1ns/1ns

module ieu_ex (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_flush,
    input  ieu_pkg::ex_op_t i_ex_op,
    output ieu_pkg::cdb_t   o_cdb
);

    import ieu_pkg::*;

    logic [DATA_WIDTH-1:0] src_a;
    logic [DATA_WIDTH-1:0] src_b;
    logic [DATA_WIDTH-1:0] alu_result;
    logic                  cmp_true;
    logic [ADDR_WIDTH-1:0] link_addr;
    logic [ADDR_WIDTH-1:0] target_base;
    logic [ADDR_WIDTH-1:0] target_addr;
    cdb_t                  cdb_d;

    assign src_a = i_ex_op.src_a;
    assign src_b = i_ex_op.src_b;

    //////////////////////////////////////////////////
    // ALU

    always_comb begin
        cmp_true   = 1'b0;
        alu_result = '0;

        case (i_ex_op.alu_func)
            ALU_ADD:  alu_result = src_a + src_b;
            ALU_SUB:  alu_result = src_a - src_b;
            ALU_AND:  alu_result = src_a & src_b;
            ALU_OR:   alu_result = src_a | src_b;
            ALU_XOR:  alu_result = src_a ^ src_b;
            ALU_SLL:  alu_result = src_a << i_ex_op.shamt;
            ALU_SRL:  alu_result = src_a >> i_ex_op.shamt;
            ALU_SRA:  alu_result = $unsigned($signed(src_a) >>> i_ex_op.shamt);
            ALU_SLT:  cmp_true   = ($signed(src_a) < $signed(src_b));
            ALU_SLTU: cmp_true   = (src_a < src_b);
            ALU_EQ:   cmp_true   = (src_a == src_b);
            ALU_NE:   cmp_true   = (src_a != src_b);
            ALU_LT:   cmp_true   = ($signed(src_a) < $signed(src_b));
            ALU_GE:   cmp_true   = ($signed(src_a) >= $signed(src_b));
            ALU_LTU:  cmp_true   = (src_a < src_b);
            ALU_GEU:  cmp_true   = (src_a >= src_b);
            default:  alu_result = '0;
        endcase

        // Set-less-than results land in bit 0
        if (i_ex_op.alu_func == ALU_SLT || i_ex_op.alu_func == ALU_SLTU) begin
            alu_result = {{(DATA_WIDTH-1){1'b0}}, cmp_true};
        end
    end

    //////////////////////////////////////////////////
    // Branch and jump targets

    // Return address and branch fall-through share one adder
    assign link_addr   = i_ex_op.iaddr + ADDR_WIDTH'(4);

    // Branches offset from the PC, jumps from src_a which ID already loaded
    assign target_base = i_ex_op.br ? i_ex_op.iaddr : src_a;
    assign target_addr = target_base + i_ex_op.imm_b;

    always_comb begin
        cdb_d.en       = i_ex_op.valid;
        cdb_d.tag      = i_ex_op.tag;
        cdb_d.redirect = 1'b0;
        cdb_d.data     = alu_result;
        cdb_d.addr     = i_ex_op.iaddr;

        if (i_ex_op.jmp) begin
            cdb_d.redirect = 1'b1;
            cdb_d.data     = link_addr;
            cdb_d.addr     = {target_addr[ADDR_WIDTH-1:1], 1'b0};  // JAL targets are even already
        end else if (i_ex_op.br) begin
            cdb_d.redirect = cmp_true;
            cdb_d.data     = '0;
            cdb_d.addr     = cmp_true ? target_addr : link_addr;
        end
    end

    always_ff @(posedge clk) begin
        o_cdb <= cdb_d;
        if (!i_rst_n || i_flush) begin
            o_cdb.en <= 1'b0;
        end
    end

endmodule

/* hw/ieu.sv */
//////////////////////////////////////////////////
// Integer execution unit top level
//////////////////////////////////////////////////

`timescale 1ns/1ns

module ieu (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_flush,
    input  ieu_pkg::fu_req_t i_fu_req,
    output ieu_pkg::cdb_t    o_cdb
);

    import ieu_pkg::*;

    ex_op_t ex_op;  // ID to EX pipeline register

    ieu_id ieu_id_inst (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_flush  (i_flush),
        .i_fu_req (i_fu_req),
        .o_ex_op  (ex_op)
    );

    ieu_ex ieu_ex_inst (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_flush  (i_flush),
        .i_ex_op  (ex_op),
        .o_cdb    (o_cdb)
    );

endmodule

/* bench/ieu_ref.svh */
//////////////////////////////////////////////////
// RV32I encoding helpers and reference model
//////////////////////////////////////////////////

`ifndef IEU_REF_SVH
`define IEU_REF_SVH

// Register fields are fixed at rd=x1, rs1=x2, rs2=x3
function automatic logic [31:0] r_type_insn(input logic [6:0] funct7, input logic [2:0] funct3);
    return {funct7, 5'd3, 5'd2, funct3, 5'd1, 7'b0110011};
endfunction

function automatic logic [31:0] i_type_insn(input logic [11:0] imm, input logic [2:0] funct3,
                                            input logic [6:0] op);
    return {imm, 5'd2, funct3, 5'd1, op};
endfunction

function automatic logic [31:0] u_type_insn(input logic [19:0] imm, input logic [6:0] op);
    return {imm, 5'd1, op};
endfunction

function automatic logic [31:0] j_type_insn(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
endfunction

function automatic logic [31:0] b_type_insn(input logic [12:0] imm, input logic [2:0] funct3);
    return {imm[12], imm[10:5], 5'd3, 5'd2, funct3, imm[4:1], imm[11], 7'b1100011};
endfunction

// Expected bus word for one request, straight from the RV32I rules
function automatic cdb_t expected_cdb(input fu_req_t r);
    cdb_t        c;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] imm_b;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    logic [2:0]  f3;
    logic        take;
    imm_i = {{20{r.insn[31]}}, r.insn[31:20]};
    imm_u = {r.insn[31:12], 12'h000};
    imm_j = {{12{r.insn[31]}}, r.insn[19:12], r.insn[20], r.insn[30:21], 1'b0};
    imm_b = {{20{r.insn[31]}}, r.insn[7], r.insn[30:25], r.insn[11:8], 1'b0};
    f3    = r.insn[14:12];
    a     = r.src_a;
    b     = (r.opcode == OPC_OPIMM) ? imm_i : r.src_b;
    sh    = (r.opcode == OPC_OPIMM) ? r.insn[24:20] : r.src_b[4:0];
    c.en       = 1'b1;
    c.redirect = 1'b0;
    c.data     = '0;
    c.addr     = r.iaddr;
    c.tag      = r.tag;
    case (r.opcode)
        OPC_LUI:   c.data = imm_u;
        OPC_AUIPC: c.data = r.iaddr + imm_u;
        OPC_JAL, OPC_JALR: begin
            c.data     = r.iaddr + 32'd4;  // Link address
            c.redirect = 1'b1;
            c.addr     = (r.opcode == OPC_JAL) ? r.iaddr + imm_j : (a + imm_i) & 32'hffff_fffe;
        end
        OPC_BRANCH: begin
            case (f3)
                3'b000:  take = (a == b);
                3'b001:  take = (a != b);
                3'b100:  take = ($signed(a) < $signed(b));
                3'b101:  take = ($signed(a) >= $signed(b));
                3'b110:  take = (a < b);
                default: take = (a >= b);
            endcase
            c.redirect = take;
            c.addr     = take ? r.iaddr + imm_b : r.iaddr + 32'd4;
        end
        default: begin
            case (f3)
                3'b000:  c.data = (r.opcode == OPC_OP && r.insn[30]) ? a - b : a + b;
                3'b001:  c.data = a << sh;
                3'b010:  c.data = {31'd0, $signed(a) < $signed(b)};
                3'b011:  c.data = {31'd0, a < b};
                3'b100:  c.data = a ^ b;
                3'b101:  c.data = r.insn[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
                3'b110:  c.data = a | b;
                default: c.data = a & b;
            endcase
        end
    endcase
    return c;
endfunction

`endif

/* bench/ieu_tb.sv */
//////////////////////////////////////////////////
// Testbench for the integer execution unit
// Directed and random requests checked against a reference model
//////////////////////////////////////////////////

`timescale 1ns/1ns

module ieu_tb;

    import ieu_pkg::*;

    `include "ieu_ref.svh"

    localparam int N_ARITH        = 200;
    localparam int N_MIX          = 400;
    localparam int N_DIRECTED     = 100;  // Directed requests with idle and drain slots
    localparam int TIMEOUT_CYCLES = (N_ARITH + N_MIX + N_DIRECTED) * 20 + 200;
    localparam logic [31:0] EDGE_A [5] = '{32'h0, 32'h8000_0000, 32'h7fff_ffff,
                                           32'hffff_ffff, 32'h1};
    localparam logic [31:0] EDGE_B [5] = '{32'h0, 32'h7fff_ffff, 32'h8000_0000,
                                           32'h1, 32'hffff_ffff};

    logic    clk;
    logic    i_rst_n;
    logic    i_flush;
    fu_req_t i_fu_req;
    cdb_t    o_cdb;

    cdb_t    exp_q[$];
    int      due_q[$];   // Negedge count at which each pulse must show
    int      cycle_cnt = 0;
    bit      last_pushed = 1'b0;
    string   test_name = "reset";

    ieu dut0 (.clk(clk), .i_rst_n(i_rst_n), .i_flush(i_flush), .i_fu_req(i_fu_req),
              .o_cdb(o_cdb));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic check_cdb(input string name, input cdb_t exp, input cdb_t act);
        if (act !== exp) begin
            abort_run($sformatf("error %s: expected %h actual %h", name, exp, act));
        end
    endtask

    function automatic fu_req_t make_req(input opcode_e opc, input logic [31:0] insn,
                                         input logic [31:0] a, input logic [31:0] b);
        fu_req_t r;
        r.valid  = 1'b1;
        r.opcode = opc;
        r.iaddr  = $urandom & 32'hffff_fffc;
        r.insn   = insn;
        r.src_a  = a;
        r.src_b  = b;
        r.tag    = ROB_IDX_WIDTH'($urandom);
        return r;
    endfunction

    // Edge values show up often so SLT, SLTU and branches see sign flips
    function automatic logic [31:0] random_operand();
        case ($urandom % 8)
            0: return 32'h0000_0000;
            1: return 32'h8000_0000;
            2: return 32'h7fff_ffff;
            3: return 32'hffff_ffff;
            default: return $urandom;
        endcase
    endfunction

    function automatic fu_req_t random_req(input opcode_e opc);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [31:0] insn;
        f3  = 3'($urandom);
        alt = 1'($urandom);
        imm = 12'($urandom);
        case (opc)
            OPC_LUI:    insn = u_type_insn(20'($urandom), 7'b0110111);
            OPC_AUIPC:  insn = u_type_insn(20'($urandom), 7'b0010111);
            OPC_JAL:    insn = j_type_insn(21'($urandom));
            OPC_JALR:   insn = i_type_insn(imm, 3'b000, 7'b1100111);
            OPC_BRANCH: insn = b_type_insn(13'($urandom), f3[2:1] == 2'b01 ? 3'b000 : f3);
            OPC_OPIMM: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm = {1'b0, alt && f3 == 3'b101, 5'd0, imm[4:0]};  // SLLI, SRLI, SRAI
                end
                insn = i_type_insn(imm, f3, 7'b0010011);
            end
            default: insn = r_type_insn({1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'd0}, f3);
        endcase
        return make_req(opc, insn, random_operand(), random_operand());
    endfunction

    // A flush drops the request beside it and the one issued a cycle earlier
    task automatic issue(input fu_req_t req, input logic flush);
        @(posedge clk);
        i_fu_req <= req;
        i_flush  <= flush;
        if (flush) begin
            if (last_pushed) begin
                void'(exp_q.pop_back());
                void'(due_q.pop_back());
            end
            last_pushed = 1'b0;
        end else begin
            last_pushed = req.valid;
            if (req.valid) begin
                exp_q.push_back(expected_cdb(req));
                due_q.push_back(cycle_cnt + 3);
            end
        end
    endtask

    task automatic drain();
        repeat (4) issue('0, 1'b0);
    endtask

    //////////////////////////////////////////////////
    // Scoreboard and watchdog

    always @(negedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (o_cdb.en === 1'b1) begin
            if (exp_q.size() == 0) begin
                abort_run("Bus pulse seen with no request outstanding");
            end else if (due_q[0] != cycle_cnt) begin
                abort_run($sformatf("error %s latency: expected cycle %0d actual cycle %0d",
                                    test_name, due_q[0], cycle_cnt));
            end else begin
                check_cdb(test_name, exp_q.pop_front(), o_cdb);
                void'(due_q.pop_front());
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        abort_run("Timeout, the run went on far longer than the tests need");
    end

    //////////////////////////////////////////////////
    // Tests

    initial begin
        logic        flush;
        void'($urandom(32'h8a01_80b5));
        i_rst_n  = 1'b0;
        i_flush  = 1'b0;
        i_fu_req = '0;
        repeat (2) @(posedge clk);
        i_rst_n <= 1'b1;

        test_name = "idle_then_addi";
        repeat (5) issue('0, 1'b0);
        issue(make_req(OPC_OPIMM, i_type_insn(12'h9ab, 3'b000, 7'b0010011), 32'h1234_5678,
                       32'h0), 1'b0);
        drain();

        test_name = "random_alu";
        repeat (N_ARITH) issue(random_req(($urandom % 2) ? OPC_OP : OPC_OPIMM), 1'b0);
        drain();

        test_name = "jumps";
        issue(make_req(OPC_LUI, u_type_insn(20'hfedcb, 7'b0110111), $urandom, $urandom), 1'b0);
        issue(make_req(OPC_AUIPC, u_type_insn(20'h80000, 7'b0010111), $urandom, $urandom), 1'b0);
        issue(make_req(OPC_JAL, j_type_insn(21'h00_0ffe), $urandom, $urandom), 1'b0);
        issue(make_req(OPC_JAL, j_type_insn(21'h1f_f000), $urandom, $urandom), 1'b0);
        issue(make_req(OPC_JALR, i_type_insn(12'h005, 3'b000, 7'b1100111), 32'h1000_0000,
                       $urandom), 1'b0);
        issue(make_req(OPC_JALR, i_type_insn(12'hfff, 3'b000, 7'b1100111), 32'h0000_2002,
                       $urandom), 1'b0);
        drain();

        test_name = "branches";
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 5; p++) begin
                issue(make_req(OPC_BRANCH, b_type_insn(13'($urandom), 3'(f < 2 ? f : f + 2)),
                               EDGE_A[p], EDGE_B[p]), 1'b0);
            end
        end
        drain();

        test_name = "flush_in_flight";
        issue(random_req(OPC_OP), 1'b0);
        issue(random_req(OPC_OPIMM), 1'b1);  // Both operations die here
        issue(random_req(OPC_OP), 1'b0);
        issue(random_req(OPC_JAL), 1'b0);
        issue(random_req(OPC_BRANCH), 1'b0);
        issue('0, 1'b1);                     // Only the branch is still in ID
        issue(random_req(OPC_LUI), 1'b0);
        drain();

        test_name = "random_mix";
        repeat (N_MIX) begin
            flush = ($urandom % 16 == 0);
            if ($urandom % 4 == 0)
                issue('0, flush);
            else
                issue(random_req(opcode_e'(3'($urandom % 7))), flush);
        end
        drain();

        if (exp_q.size() != 0) begin
            abort_run($sformatf("Scoreboard still holds %0d results at the end", exp_q.size()));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* all.f */
+incdir+bench
hw/ieu_pkg.sv
hw/ieu_id.sv
hw/ieu_ex.sv
hw/ieu.sv
bench/ieu_tb.sv

/* run.sh */
#!/bin/sh
# Builds the integer execution unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
    --top-module ieu_tb -f all.f -o ieu_sim

./obj_dir/ieu_sim | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failures"
